//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cpu_tb -o cpu_tb_sim
	./obj_dir/cpu_tb_sim > sim.log 2>&1; cat sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/cpu_tb.sv
`default_nettype none

`include "cpu_params.svh"

module cpu_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import cpu_pkg::*;

	localparam int NUM_ENTRIES = 26; // 8 ALU, 1 load-use, 16 branch, 1 BR/PCS
	localparam int CLK_PERIOD  = 20;

	// One test: op selects the program shape
	typedef struct {
		opcode_e op;
		cond_e   cond;
		word_t   a;
		word_t   b;
		word_t   exp_addr; // Last store
		word_t   exp_data;
		int      exp_count;
	} entry_t;

	logic        clk;
	logic        reset;
	word_t       instr, data_rdata, instr_addr, data_addr, data_wdata, pc_out;
	logic        data_write, hlt;
	entry_t      tests [NUM_ENTRIES];
	logic [31:0] lcg_state;
	int          prog_len; // Next free ROM word

	cpu u_cpu (
		.clk        (clk),
		.reset      (reset),
		.instr      (instr),
		.data_rdata (data_rdata),
		.instr_addr (instr_addr),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.data_write (data_write),
		.pc_out     (pc_out),
		.hlt        (hlt)
	);

	tb_memory u_mem (
		.clk        (clk),
		.reset      (reset),
		.instr_addr (instr_addr),
		.instr      (instr),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.data_write (data_write),
		.data_rdata (data_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// --------------------
	// Reporting and checks
	// --------------------
	task automatic report_fail();
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("error at %0d ns: %s got %h expected %h", $time, name, got, exp);
			report_fail();
		end
	endtask

	task automatic check_addr(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("error at %0d ns: %s got address %h expected %h", $time, name, got, exp);
			report_fail();
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("error at %0d ns: %s got %b expected %b", $time, name, got, exp);
			report_fail();
		end
	endtask

	task automatic check_count(int entry, int got, int exp);
		if (got != exp) begin
			$display("test %0d saw %0d stores where %0d were expected at %0d ns",
				entry, got, exp, $time);
			report_fail();
		end
	endtask

	// LCG, upper bits are the better ones
	function automatic word_t next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// --------------------
	// Reference model
	// --------------------
	function automatic word_t saturate(int s);
		if (s > 32767) return 16'h7FFF;
		if (s < -32768) return 16'h8000;
		return word_t'(s);
	endfunction

	function automatic word_t ref_alu(opcode_e op, word_t a, word_t b);
		word_t r;
		int    amt;
		amt = int'(b[3:0]); // Shift amount from the rt field
		case (op)
			OP_ADD: r = saturate(int'($signed(a)) + int'($signed(b)));
			OP_SUB: r = saturate(int'($signed(a)) - int'($signed(b)));
			OP_XOR: r = a ^ b;
			OP_AND: r = a & b;
			OP_SLL: r = a << amt;
			OP_SRA: r = word_t'($signed(a) >>> amt);
			OP_ROR: begin
				r = a;
				for (int i = 0; i < amt; i++) r = {r[0], r[15:1]};
			end
			default: r = a | b;
		endcase
		return r;
	endfunction

	// Flags come from the SUB right before the branch
	function automatic logic ref_taken(cond_e c, word_t a, word_t b);
		int    s;
		word_t r;
		logic  z, v, n;
		s = int'($signed(a)) - int'($signed(b));
		r = ref_alu(OP_SUB, a, b);
		z = (r == 16'h0000);
		v = (s > 32767) || (s < -32768);
		n = r[15];
		case (c)
			COND_NE: return !z;
			COND_EQ: return z;
			COND_GT: return !z && !n;
			COND_LT: return n;
			COND_GE: return z || !n;
			COND_LE: return z || n;
			COND_OV: return v;
			default: return 1'b1;
		endcase
	endfunction

	// Test table with random operands
	task automatic fill_tests();
		int idx;
		idx = 0;
		for (int k = 0; k < 8; k++) begin
			tests[idx].op        = opcode_e'(4'(k));
			tests[idx].cond      = COND_AL;
			tests[idx].a         = next_rand();
			tests[idx].b         = next_rand();
			tests[idx].exp_addr  = 16'h0008;
			tests[idx].exp_data  = ref_alu(tests[idx].op, tests[idx].a, tests[idx].b);
			tests[idx].exp_count = 1;
			idx++;
		end
		tests[idx] = '{OP_LW, COND_AL, next_rand(), 16'h0, 16'h0024, 16'h0, 2};
		tests[idx].exp_data = tests[idx].a; // Loaded back unchanged
		idx++;
		for (int c = 0; c < 8; c++) begin
			for (int v = 0; v < 2; v++) begin
				tests[idx].op   = OP_B;
				tests[idx].cond = cond_e'(3'(c));
				tests[idx].a    = next_rand();
				tests[idx].b    = next_rand();
				if (v == 1 && tests[idx].cond == COND_OV) begin
					tests[idx].a = 16'h7000; // Forces signed overflow
					tests[idx].b = 16'h9000;
				end else if (v == 1) begin
					tests[idx].b = tests[idx].a; // Zero result
				end
				tests[idx].exp_addr  = 16'h0008;
				tests[idx].exp_data  = ref_alu(OP_SUB, tests[idx].a, tests[idx].b);
				tests[idx].exp_count = ref_taken(tests[idx].cond, tests[idx].a,
					tests[idx].b) ? 1 : 3;
				idx++;
			end
		end
		tests[idx] = '{OP_BR, COND_AL, 16'h0, 16'h0, 16'h0006, 16'h000E, 1}; // PCS at 12
	endtask

	// --------------------
	// Program builder
	// --------------------
	function automatic word_t enc(opcode_e op, logic [3:0] f1, logic [3:0] f2, logic [3:0] f3);
		return {op, f1, f2, f3};
	endfunction

	task automatic emit(word_t w);
		u_mem.rom[prog_len] = w;
		prog_len++;
	endtask

	task automatic load_operand(logic [3:0] rd, word_t val);
		emit(enc(OP_LLB, rd, val[7:4], val[3:0]));
		emit(enc(OP_LHB, rd, val[15:12], val[11:8])); // Depends on the LLB just before
	endtask

	task automatic load_program(entry_t e);
		prog_len = 0;
		if (e.op == OP_LW) begin
			load_operand(4'd1, e.a);
			emit(enc(OP_LLB, 4'd5, 4'h2, 4'h0)); // Base 0x0020
			emit(enc(OP_SW, 4'd1, 4'd5, 4'd1));
			emit(enc(OP_LW, 4'd6, 4'd5, 4'd1));
			emit(enc(OP_ADD, 4'd7, 4'd6, 4'd0)); // Load-use stall here
			emit(enc(OP_SW, 4'd7, 4'd5, 4'd2));
		end else if (e.op == OP_B) begin
			load_operand(4'd1, e.a);
			load_operand(4'd2, e.b);
			emit(enc(OP_SUB, 4'd3, 4'd1, 4'd2));
			emit(enc(OP_B, {e.cond, 1'b0}, 4'h0, 4'h2)); // Skips the two markers
			emit(enc(OP_SW, 4'd1, 4'd0, 4'd1));
			emit(enc(OP_SW, 4'd2, 4'd0, 4'd2));
			emit(enc(OP_SW, 4'd3, 4'd0, 4'd4));
		end else if (e.op == OP_BR) begin
			emit(enc(OP_LLB, 4'd2, 4'h0, 4'h8));
			emit(enc(OP_LLB, 4'd3, 4'h0, 4'h4));
			emit(enc(OP_ADD, 4'd1, 4'd2, 4'd3)); // Target 12
			emit(enc(OP_BR, {COND_AL, 1'b0}, 4'd1, 4'h0));
			emit(enc(OP_SW, 4'd1, 4'd0, 4'd1));
			emit(enc(OP_SW, 4'd1, 4'd0, 4'd2));
			emit(enc(OP_PCS, 4'd4, 4'h0, 4'h0));
			emit(enc(OP_SW, 4'd4, 4'd0, 4'd3));
		end else begin
			load_operand(4'd1, e.a);
			load_operand(4'd2, e.b);
			if (e.op inside {OP_SLL, OP_SRA, OP_ROR})
				emit(enc(e.op, 4'd3, 4'd1, e.b[3:0]));
			else
				emit(enc(e.op, 4'd3, 4'd1, 4'd2));
			emit(enc(OP_SW, 4'd3, 4'd0, 4'd4)); // Store data forwarded
		end
		emit(enc(OP_HLT, 4'h0, 4'h0, 4'h0));
	endtask

	// Reset, run to HLT, compare, then watch the halted core
	task automatic run_entry(int i);
		word_t held_pc;
		int    held_count;
		int    last;
		@(posedge clk);
		reset <= 1'b1;
		load_program(tests[i]);
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_bit("hlt", hlt, 1'b0);
		check_bit("data_write", data_write, 1'b0);
		check_addr("pc_out", pc_out, `CPU_RESET_PC);
		while (!hlt) @(negedge clk);
		check_count(i, u_mem.store_count, tests[i].exp_count);
		last = u_mem.store_count - 1;
		check_addr("data_addr", u_mem.store_addr[last], tests[i].exp_addr);
		check_word("data_wdata", u_mem.store_data[last], tests[i].exp_data);
		held_pc    = pc_out;
		held_count = u_mem.store_count;
		repeat (10) begin
			@(negedge clk);
			check_bit("hlt", hlt, 1'b1);
			check_bit("data_write", data_write, 1'b0);
		end
		check_addr("pc_out", pc_out, held_pc);
		check_count(i, u_mem.store_count, held_count);
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		reset     = 1'b1;
		lcg_state = 32'd68;
		prog_len  = 0;
		fill_tests();
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			run_entry(i);
		end
		$display("PASS: all tests");
		$finish;
	end

	// Watchdog, 64 cycles per test
	initial begin
		#(64 * NUM_ENTRIES * CLK_PERIOD);
		$display("watchdog expired before all tests finished");
		report_fail();
	end

endmodule

`default_nettype wire

//--- bench/tb_memory.sv
`default_nettype none

module tb_memory (
	input  logic           clk,
	input  logic           reset,
	input  cpu_pkg::word_t instr_addr,
	output cpu_pkg::word_t instr,
	input  cpu_pkg::word_t data_addr,
	input  cpu_pkg::word_t data_wdata,
	input  logic           data_write,
	output cpu_pkg::word_t data_rdata
);
	timeunit 1ns;
	timeprecision 1ps;
	import cpu_pkg::*;

	localparam int ROM_WORDS  = 64;
	localparam int RAM_WORDS  = 32768; // Full 16-bit byte address space
	localparam int MAX_STORES = 16;

	word_t rom [ROM_WORDS]; // Written by the testbench per program
	word_t ram [RAM_WORDS];
	word_t store_addr [MAX_STORES]; // Store log, in order
	word_t store_data [MAX_STORES];
	int    store_count;

	// --------------------
	// Fill patterns
	// --------------------
	initial begin
		for (int i = 0; i < ROM_WORDS; i++) begin
			rom[i] = {4'hF, 12'(i * 2)}; // HLT with the byte address in the low bits
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			ram[i] = word_t'(i * 2) ^ 16'hC3A5;
		end
	end

	assign instr      = rom[instr_addr[6:1]]; // Same-cycle fetch
	assign data_rdata = ram[data_addr[15:1]]; // Combinational read

	// Store port, one word per strobe
	always @(posedge clk) begin
		if (reset) begin
			store_count <= 0;
		end else if (data_write) begin
			ram[data_addr[15:1]] <= data_wdata;
			if (store_count < MAX_STORES) begin
				store_addr[store_count] <= data_addr;
				store_data[store_count] <= data_wdata;
			end
			store_count <= store_count + 1;
		end
	end

endmodule

`default_nettype wire

//--- include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// --------------------
// Core sizing
// --------------------

// Data word and address width
`define CPU_WORD_W 16

// Architectural registers, r0 reads as zero
`define CPU_REG_COUNT 16

// --------------------
// Reset state
// --------------------

`define CPU_RESET_PC 16'h0000 // First fetch address

`endif

//--- logic/cpu.sv
`default_nettype none

module cpu (
	input  logic           clk,
	input  logic           reset,
	input  cpu_pkg::word_t instr,
	input  cpu_pkg::word_t data_rdata,
	output cpu_pkg::word_t instr_addr,
	output cpu_pkg::word_t data_addr,
	output cpu_pkg::word_t data_wdata,
	output logic           data_write,
	output cpu_pkg::word_t pc_out,
	output logic           hlt
);
	import cpu_pkg::*;

	// --------------------
	// Stage links
	// --------------------
	logic     stall, flush, redirect, halt_seen;
	word_t    redirect_pc;

	word_t    id_instr, id_pc_next; // Fetch to decode
	logic     id_valid;

	logic     ex_valid; // Decode to execute
	opcode_e  ex_opcode;
	reg_idx_t ex_rs, ex_rt, ex_rd;
	word_t    ex_src1, ex_src2, ex_imm, ex_pc_next;

	logic     mem_valid; // Execute to result
	opcode_e  mem_opcode;
	reg_idx_t mem_rd;
	word_t    mem_alu_result, mem_store_data, mem_addr_calc;

	logic     wb_write; // Writeback, back to decode and execute
	reg_idx_t wb_rd;
	word_t    wb_data;

	fetch_stage u_fetch (
		.clk         (clk),
		.reset       (reset),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.halt_seen   (halt_seen),
		.instr       (instr),
		.instr_addr  (instr_addr),
		.pc_out      (pc_out),
		.hlt         (hlt),
		.id_instr    (id_instr),
		.id_pc_next  (id_pc_next),
		.id_valid    (id_valid)
	);

	decode_stage u_decode (
		.clk        (clk),
		.reset      (reset),
		.id_instr   (id_instr),
		.id_pc_next (id_pc_next),
		.id_valid   (id_valid),
		.flush      (flush),
		.wb_write   (wb_write),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.stall      (stall),
		.ex_valid   (ex_valid),
		.ex_opcode  (ex_opcode),
		.ex_rs      (ex_rs),
		.ex_rt      (ex_rt),
		.ex_rd      (ex_rd),
		.ex_src1    (ex_src1),
		.ex_src2    (ex_src2),
		.ex_imm     (ex_imm),
		.ex_pc_next (ex_pc_next)
	);

	execute_stage u_execute (
		.clk            (clk),
		.reset          (reset),
		.ex_valid       (ex_valid),
		.ex_opcode      (ex_opcode),
		.ex_rs          (ex_rs),
		.ex_rt          (ex_rt),
		.ex_rd          (ex_rd),
		.ex_src1        (ex_src1),
		.ex_src2        (ex_src2),
		.ex_imm         (ex_imm),
		.ex_pc_next     (ex_pc_next),
		.wb_write       (wb_write),
		.wb_rd          (wb_rd),
		.wb_data        (wb_data),
		.redirect       (redirect),
		.redirect_pc    (redirect_pc),
		.flush          (flush),
		.halt_seen      (halt_seen),
		.mem_valid      (mem_valid),
		.mem_opcode     (mem_opcode),
		.mem_rd         (mem_rd),
		.mem_alu_result (mem_alu_result),
		.mem_store_data (mem_store_data),
		.mem_addr_calc  (mem_addr_calc)
	);

	result_stage u_result (
		.clk            (clk),
		.reset          (reset),
		.mem_valid      (mem_valid),
		.mem_opcode     (mem_opcode),
		.mem_rd         (mem_rd),
		.mem_alu_result (mem_alu_result),
		.mem_store_data (mem_store_data),
		.mem_addr_calc  (mem_addr_calc),
		.data_rdata     (data_rdata),
		.data_addr      (data_addr),
		.data_wdata     (data_wdata),
		.data_write     (data_write),
		.wb_write       (wb_write),
		.wb_rd          (wb_rd),
		.wb_data        (wb_data)
	);

endmodule

`default_nettype wire

//--- logic/cpu_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

	typedef logic [`CPU_WORD_W-1:0] word_t; // Data or address word
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t; // Register number

	// Top nibble of the instruction
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_AND = 4'h3,
		OP_SLL = 4'h4,
		OP_SRA = 4'h5,
		OP_ROR = 4'h6,
		OP_OR  = 4'h7,
		OP_LW  = 4'h8, // Load word
		OP_SW  = 4'h9, // Store word
		OP_LHB = 4'hA, // Load high byte
		OP_LLB = 4'hB, // Load low byte
		OP_B   = 4'hC, // Branch by immediate
		OP_BR  = 4'hD, // Branch to register
		OP_PCS = 4'hE, // Save PC+2
		OP_HLT = 4'hF
	} opcode_e;

	// Branch condition, bits 11:9 of B and BR
	typedef enum logic [2:0] {
		COND_NE = 3'd0,
		COND_EQ = 3'd1,
		COND_GT = 3'd2,
		COND_LT = 3'd3,
		COND_GE = 3'd4,
		COND_LE = 3'd5,
		COND_OV = 3'd6,
		COND_AL = 3'd7
	} cond_e;

	// ALU operation, low three opcode bits
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_XOR = 3'd2,
		ALU_AND = 3'd3,
		ALU_SLL = 3'd4,
		ALU_SRA = 3'd5,
		ALU_ROR = 3'd6,
		ALU_OR  = 3'd7
	} alu_op_e;

	typedef struct packed {
		logic z; // Zero
		logic v; // Signed overflow
		logic n; // Negative
	} flags_t;

	// Opcodes that end in a register write
	function automatic logic writes_reg(opcode_e op);
		return !op[3] || (op inside {OP_LW, OP_LHB, OP_LLB, OP_PCS});
	endfunction

endpackage

`default_nettype wire

//--- logic/decode_stage.sv
`default_nettype none

module decode_stage (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::word_t     id_instr,
	input  cpu_pkg::word_t     id_pc_next,
	input  logic               id_valid,
	input  logic               flush,
	input  logic               wb_write,
	input  cpu_pkg::reg_idx_t  wb_rd,
	input  cpu_pkg::word_t     wb_data,
	output logic               stall,
	output logic               ex_valid,
	output cpu_pkg::opcode_e   ex_opcode,
	output cpu_pkg::reg_idx_t  ex_rs,
	output cpu_pkg::reg_idx_t  ex_rt,
	output cpu_pkg::reg_idx_t  ex_rd,
	output cpu_pkg::word_t     ex_src1,
	output cpu_pkg::word_t     ex_src2,
	output cpu_pkg::word_t     ex_imm,
	output cpu_pkg::word_t     ex_pc_next
);
	import cpu_pkg::*;

	opcode_e  op;
	reg_idx_t f_rd, f_rs, f_rt; // Raw instruction fields
	reg_idx_t src1_idx, src2_idx;
	logic     use1, use2; // Source actually read by this opcode
	word_t    rf_data1, rf_data2;
	word_t    imm;

	// --------------------
	// Field split
	// --------------------
	assign op   = opcode_e'(id_instr[15:12]);
	assign f_rd = id_instr[11:8];
	assign f_rs = id_instr[7:4];
	assign f_rt = id_instr[3:0];

	// SW stores rd, LHB and LLB keep the other byte of rd
	assign src1_idx = (op inside {OP_SW, OP_LHB, OP_LLB}) ? f_rd : f_rs;
	assign src2_idx = (op inside {OP_LW, OP_SW}) ? f_rs : f_rt; // Base register for memory ops

	assign use1 = !op[3] || (op inside {OP_SW, OP_LHB, OP_LLB, OP_BR});
	assign use2 = op inside {OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_OR, OP_LW, OP_SW};

	// Immediate, already extended for execute
	always_comb begin
		case (op)
			OP_SLL, OP_SRA, OP_ROR: imm = word_t'(id_instr[3:0]); // Shift amount
			OP_LW, OP_SW:           imm = word_t'($signed({id_instr[3:0], 1'b0}));
			OP_LHB, OP_LLB:         imm = word_t'(id_instr[7:0]);
			OP_B:                   imm = word_t'($signed({id_instr[8:0], 1'b0}));
			default:                imm = '0;
		endcase
	end

	register_file u_register_file (
		.clk      (clk),
		.reset    (reset),
		.rd_idx1  (src1_idx),
		.rd_idx2  (src2_idx),
		.wr_en    (wb_write),
		.wr_idx   (wb_rd),
		.wr_data  (wb_data),
		.rd_data1 (rf_data1),
		.rd_data2 (rf_data2)
	);

	// --------------------
	// Load-use hazard
	// --------------------
	// Load data is only forwardable from writeback, one bubble needed
	assign stall = id_valid && ex_valid && ex_opcode == OP_LW && ex_rd != '0 &&
		((use1 && src1_idx == ex_rd) || (use2 && src2_idx == ex_rd));

	// Decode/execute register
	always_ff @(posedge clk) begin
		if (reset || flush || stall) begin
			ex_valid <= 1'b0; // Bubble
		end else begin
			ex_valid <= id_valid;
		end
	end

	always_ff @(posedge clk) begin
		ex_opcode  <= op;
		ex_rs      <= src1_idx;
		ex_rt      <= src2_idx;
		ex_rd      <= f_rd; // Also carries the branch condition
		ex_src1    <= rf_data1;
		ex_src2    <= rf_data2;
		ex_imm     <= imm;
		ex_pc_next <= id_pc_next;
	end

	// Waiting instruction held for exactly one cycle, then enters execute once
	a_bubble: assert property (@(posedge clk) disable iff (reset)
		stall |=> !stall && $stable(id_instr) && $stable(id_valid));

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`default_nettype none

module execute_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              ex_valid,
	input  cpu_pkg::opcode_e  ex_opcode,
	input  cpu_pkg::reg_idx_t ex_rs,
	input  cpu_pkg::reg_idx_t ex_rt,
	input  cpu_pkg::reg_idx_t ex_rd,
	input  cpu_pkg::word_t    ex_src1,
	input  cpu_pkg::word_t    ex_src2,
	input  cpu_pkg::word_t    ex_imm,
	input  cpu_pkg::word_t    ex_pc_next,
	input  logic              wb_write,
	input  cpu_pkg::reg_idx_t wb_rd,
	input  cpu_pkg::word_t    wb_data,
	output logic              redirect,
	output cpu_pkg::word_t    redirect_pc,
	output logic              flush,
	output logic              halt_seen,
	output logic              mem_valid,
	output cpu_pkg::opcode_e  mem_opcode,
	output cpu_pkg::reg_idx_t mem_rd,
	output cpu_pkg::word_t    mem_alu_result,
	output cpu_pkg::word_t    mem_store_data,
	output cpu_pkg::word_t    mem_addr_calc
);
	import cpu_pkg::*;

	localparam int    MSB     = $bits(word_t) - 1;
	localparam word_t MAX_POS = {1'b0, {MSB{1'b1}}}; // Saturation limits
	localparam word_t MIN_NEG = ~MAX_POS;

	alu_op_e alu_op;
	cond_e   cond;
	flags_t  flags_q, flags_d;
	logic    mem_fwd_ok; // Execute/result holds a forwardable value
	word_t   op1, op2, alu_b;
	word_t   sum, diff, alu_out, ex_result, addr_calc;
	logic    ovf, cond_ok, taken;

	// --------------------
	// Forwarding
	// --------------------
	assign mem_fwd_ok = mem_valid && writes_reg(mem_opcode) && mem_opcode != OP_LW;

	function automatic word_t fwd(reg_idx_t idx, word_t rf_val);
		if (idx == '0) return rf_val; // r0 is never forwarded
		if (mem_fwd_ok && mem_rd == idx) return mem_alu_result;
		if (wb_write && wb_rd == idx) return wb_data;
		return rf_val;
	endfunction

	always_comb begin
		op1 = fwd(ex_rs, ex_src1);
		op2 = fwd(ex_rt, ex_src2);
	end

	// --------------------
	// ALU
	// --------------------
	assign alu_op = alu_op_e'(ex_opcode[2:0]);
	assign alu_b  = (alu_op inside {ALU_SLL, ALU_SRA, ALU_ROR}) ? ex_imm : op2;
	assign sum    = op1 + alu_b;
	assign diff   = op1 - alu_b;

	always_comb begin
		ovf = 1'b0;
		case (alu_op)
			ALU_ADD: begin
				ovf     = (op1[MSB] == alu_b[MSB]) && (sum[MSB] != op1[MSB]);
				alu_out = ovf ? (op1[MSB] ? MIN_NEG : MAX_POS) : sum; // Saturate
			end
			ALU_SUB: begin
				ovf     = (op1[MSB] != alu_b[MSB]) && (diff[MSB] != op1[MSB]);
				alu_out = ovf ? (op1[MSB] ? MIN_NEG : MAX_POS) : diff;
			end
			ALU_XOR: alu_out = op1 ^ alu_b;
			ALU_AND: alu_out = op1 & alu_b;
			ALU_SLL: alu_out = op1 << alu_b[3:0];
			ALU_SRA: alu_out = word_t'($signed(op1) >>> alu_b[3:0]);
			ALU_ROR: alu_out = (op1 >> alu_b[3:0]) | (op1 << ($bits(word_t) - alu_b[3:0]));
			default: alu_out = op1 | alu_b; // OR
		endcase
	end

	assign flags_d = '{z: alu_out == '0, v: ovf, n: alu_out[MSB]};

	// Flag register, add and sub set all three, the rest only Z
	always_ff @(posedge clk) begin
		if (reset) begin
			flags_q <= '0;
		end else if (ex_valid && !ex_opcode[3]) begin
			if (alu_op inside {ALU_ADD, ALU_SUB}) flags_q <= flags_d;
			else flags_q.z <= flags_d.z;
		end
	end

	// Value headed for the register file
	always_comb begin
		case (ex_opcode)
			OP_LHB:  ex_result = {ex_imm[7:0], op1[7:0]};
			OP_LLB:  ex_result = {op1[15:8], ex_imm[7:0]};
			OP_PCS:  ex_result = ex_pc_next;
			default: ex_result = alu_out;
		endcase
	end

	assign addr_calc = (op2 & ~word_t'(1)) + ex_imm; // Even base plus scaled offset

	// --------------------
	// Branch
	// --------------------
	assign cond = cond_e'(ex_rd[3:1]);

	always_comb begin
		case (cond)
			COND_NE: cond_ok = !flags_q.z;
			COND_EQ: cond_ok = flags_q.z;
			COND_GT: cond_ok = !flags_q.z && !flags_q.n;
			COND_LT: cond_ok = flags_q.n;
			COND_GE: cond_ok = flags_q.z || !flags_q.n;
			COND_LE: cond_ok = flags_q.z || flags_q.n;
			COND_OV: cond_ok = flags_q.v;
			default: cond_ok = 1'b1; // Always
		endcase
	end

	assign taken       = ex_valid && (ex_opcode inside {OP_B, OP_BR}) && cond_ok;
	assign redirect    = taken;
	assign redirect_pc = (ex_opcode == OP_BR) ? op1 : ex_pc_next + ex_imm;
	assign halt_seen   = ex_valid && ex_opcode == OP_HLT;
	assign flush       = taken || halt_seen; // Younger instructions die

	// Execute/result register
	always_ff @(posedge clk) begin
		if (reset) mem_valid <= 1'b0;
		else mem_valid <= ex_valid;
	end

	always_ff @(posedge clk) begin
		mem_opcode     <= ex_opcode;
		mem_rd         <= ex_rd;
		mem_alu_result <= ex_result;
		mem_store_data <= op1; // SW data from rd
		mem_addr_calc  <= addr_calc;
	end

	// Slot behind a taken branch is a bubble and never redirects again
	a_redirect: assert property (@(posedge clk) disable iff (reset)
		redirect |=> !ex_valid && !redirect);

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
`default_nettype none

`include "cpu_params.svh"

module fetch_stage (
	input  logic           clk,
	input  logic           reset,
	input  logic           stall,
	input  logic           redirect,
	input  cpu_pkg::word_t redirect_pc,
	input  logic           halt_seen,
	input  cpu_pkg::word_t instr,
	output cpu_pkg::word_t instr_addr,
	output cpu_pkg::word_t pc_out,
	output logic           hlt,
	output cpu_pkg::word_t id_instr,
	output cpu_pkg::word_t id_pc_next,
	output logic           id_valid
);
	import cpu_pkg::*;

	word_t pc;
	word_t pc_plus_2;
	logic  advance; // PC moves on sequentially

	assign pc_plus_2  = pc + word_t'(2);
	assign advance    = !stall && !hlt && !halt_seen; // Frozen once HLT reaches execute
	assign instr_addr = pc; // ROM answers in the same cycle
	assign pc_out     = pc;

	// --------------------
	// Program counter
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `CPU_RESET_PC;
		end else if (redirect) begin
			pc <= redirect_pc; // Taken branch wins over stall
		end else if (advance) begin
			pc <= pc_plus_2;
		end
	end

	// Halt latch, held until reset
	always_ff @(posedge clk) begin
		if (reset) begin
			hlt <= 1'b0;
		end else if (halt_seen) begin
			hlt <= 1'b1;
		end
	end

	// --------------------
	// Fetch/decode register
	// --------------------
	always_ff @(posedge clk) begin
		if (reset || redirect || halt_seen) begin
			id_valid <= 1'b0; // Squash the wrong-path fetch
		end else if (!stall) begin
			id_valid <= !hlt;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			id_instr   <= instr;
			id_pc_next <= pc_plus_2; // Needed by B and PCS
		end
	end

	// BR targets come from a register, so an odd target is a software fault
	a_pc_even: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0);

endmodule

`default_nettype wire

//--- logic/register_file.sv
`default_nettype none

`include "cpu_params.svh"

module register_file (
	input  logic              clk,
	input  logic              reset,
	input  cpu_pkg::reg_idx_t rd_idx1,
	input  cpu_pkg::reg_idx_t rd_idx2,
	input  logic              wr_en,
	input  cpu_pkg::reg_idx_t wr_idx,
	input  cpu_pkg::word_t    wr_data,
	output cpu_pkg::word_t    rd_data1,
	output cpu_pkg::word_t    rd_data2
);
	import cpu_pkg::*;

	word_t regs [`CPU_REG_COUNT];

	// Write port, r0 never written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Read ports with same-cycle write bypass
	always_comb begin
		rd_data1 = regs[rd_idx1];
		rd_data2 = regs[rd_idx2];
		if (wr_en && wr_idx == rd_idx1) rd_data1 = wr_data;
		if (wr_en && wr_idx == rd_idx2) rd_data2 = wr_data;
		if (rd_idx1 == '0) rd_data1 = '0; // r0 hardwired
		if (rd_idx2 == '0) rd_data2 = '0;
	end

endmodule

`default_nettype wire

//--- logic/result_stage.sv
`default_nettype none

module result_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              mem_valid,
	input  cpu_pkg::opcode_e  mem_opcode,
	input  cpu_pkg::reg_idx_t mem_rd,
	input  cpu_pkg::word_t    mem_alu_result,
	input  cpu_pkg::word_t    mem_store_data,
	input  cpu_pkg::word_t    mem_addr_calc,
	input  cpu_pkg::word_t    data_rdata,
	output cpu_pkg::word_t    data_addr,
	output cpu_pkg::word_t    data_wdata,
	output logic              data_write,
	output logic              wb_write,
	output cpu_pkg::reg_idx_t wb_rd,
	output cpu_pkg::word_t    wb_data
);
	import cpu_pkg::*;

	word_t result;
	logic  do_write; // Register write from this slot

	// --------------------
	// Data memory port
	// --------------------
	assign data_addr  = mem_addr_calc;
	assign data_wdata = mem_store_data;
	assign data_write = mem_valid && mem_opcode == OP_SW; // One strobe per store

	// Loaded data or execute result
	assign result   = (mem_opcode == OP_LW) ? data_rdata : mem_alu_result;
	assign do_write = mem_valid && writes_reg(mem_opcode) && mem_rd != '0;

	// --------------------
	// Result/writeback register
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_write <= 1'b0;
		end else begin
			wb_write <= do_write;
		end
	end

	always_ff @(posedge clk) begin
		wb_rd   <= mem_rd;
		wb_data <= result; // Read combinationally, captured here
	end

	// Stores land on even byte addresses
	a_store: assert property (@(posedge clk) disable iff (reset)
		data_write |-> data_addr[0] == 1'b0);

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/cpu.sv
bench/tb_memory.sv
bench/cpu_tb.sv
